/* dv/core_perf_props.sv */
`timescale 1ns/100ps

module core_perf_props #(
    parameter int NUM_LANES = 4
) (
    input logic                                     clk,
    input logic                                     reset,
    input core_perf_pkg::mpm_class_e                mpm_class,
    input logic [core_perf_pkg::PERF_CTR_BITS-1:0]  ifetches,
    input logic [core_perf_pkg::PERF_CTR_BITS-1:0]  loads,
    input logic [core_perf_pkg::PERF_CTR_BITS-1:0]  stores,
    input logic [core_perf_pkg::PERF_CTR_BITS-1:0]  ifetch_latency,
    input logic [core_perf_pkg::PERF_CTR_BITS-1:0]  load_latency
);
    import core_perf_pkg::*;

    // Latency sums may fall with negative pending, so only event counts here
    no_decrease: assert property (@(posedge clk) disable iff (reset)
        ifetches >= $past(ifetches) && loads >= $past(loads) && stores >= $past(stores))
        else $error("An event counter went down");

    lane_limit: assert property (@(posedge clk) disable iff (reset)
        (loads + stores) - ($past(loads) + $past(stores)) <= PERF_CTR_BITS'(NUM_LANES))
        else $error("Loads and stores grew by more than the lane count in one cycle");

    frozen_when_off: assert property (@(posedge clk) disable iff (reset)
        $past(mpm_class) == MPM_NONE |->
            ifetches == $past(ifetches) && loads == $past(loads) && stores == $past(stores)
            && ifetch_latency == $past(ifetch_latency) && load_latency == $past(load_latency))
        else $error("A counter moved while the monitor class was none");

endmodule

bind perf_counters core_perf_props #(
    .NUM_LANES (NUM_LANES)
) props (
    .clk            (clk),
    .reset          (reset),
    .mpm_class      (base_dcrs.mpm_class),
    .ifetches       (ifetches),
    .loads          (loads),
    .stores         (stores),
    .ifetch_latency (ifetch_latency),
    .load_latency   (load_latency)
);

/* dv/core_perf_tb.sv */
`timescale 1ns/100ps

module core_perf_tb;
    import core_perf_pkg::*;

    localparam int NUM_LANES      = 4;
    localparam int CLK_PERIOD     = 20;
    localparam int DCR_CYCLES     = 60;
    localparam int IDLE_CYCLES    = 200;
    localparam int CORE_CYCLES    = 500;
    localparam int BOUNDED_CYCLES = 400;
    localparam int PHASE_CYCLES   = 100;
    // Two resets, five class writes and the traffic of every test
    localparam int TOTAL_CYCLES   = 2 * 3 + 5 + DCR_CYCLES + IDLE_CYCLES + CORE_CYCLES
                                    + BOUNDED_CYCLES + 3 * PHASE_CYCLES;

    logic                         clk;
    logic                         reset;
    logic                         dcr_write_valid;
    logic [DCR_ADDR_WIDTH-1:0]    dcr_write_addr;
    logic [DCR_DATA_WIDTH-1:0]    dcr_write_data;
    logic                         icache_req_valid;
    logic                         icache_req_ready;
    logic                         icache_rsp_valid;
    logic                         icache_rsp_ready;
    logic [NUM_LANES-1:0]         dcache_req_valid;
    logic [NUM_LANES-1:0]         dcache_req_rw;
    logic [NUM_LANES-1:0]         dcache_req_ready;
    logic [NUM_LANES-1:0]         dcache_rsp_valid;
    logic [NUM_LANES-1:0]         dcache_rsp_ready;
    logic [STARTUP_ADDR_BITS-1:0] startup_addr;
    mpm_class_e                   mpm_class;
    logic [PERF_CTR_BITS-1:0]     perf_ifetches;
    logic [PERF_CTR_BITS-1:0]     perf_loads;
    logic [PERF_CTR_BITS-1:0]     perf_stores;
    logic [PERF_CTR_BITS-1:0]     perf_ifetch_latency;
    logic [PERF_CTR_BITS-1:0]     perf_load_latency;

    // Reference model state
    logic [STARTUP_ADDR_BITS-1:0]    m_startup;
    mpm_class_e                      m_class;
    logic [PERF_CTR_BITS-1:0]        m_ifetches;
    logic [PERF_CTR_BITS-1:0]        m_loads;
    logic [PERF_CTR_BITS-1:0]        m_stores;
    logic [PERF_CTR_BITS-1:0]        m_ilat;
    logic [PERF_CTR_BITS-1:0]        m_dlat;
    logic signed [PERF_CTR_BITS-1:0] m_ipend;
    logic signed [PERF_CTR_BITS-1:0] m_dpend;

    logic [PERF_CTR_BITS-1:0] frozen_ifetches;
    logic [PERF_CTR_BITS-1:0] frozen_loads;
    logic [PERF_CTR_BITS-1:0] frozen_stores;
    logic [PERF_CTR_BITS-1:0] frozen_ilat;
    logic [PERF_CTR_BITS-1:0] frozen_dlat;

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          errors_at_start;
    int          checks_at_start;
    int          test_num;
    int          tests_failed;

    core_perf_top #(
        .NUM_LANES (NUM_LANES)
    ) DUT (
        .clk                 (clk),
        .reset               (reset),
        .dcr_write_valid     (dcr_write_valid),
        .dcr_write_addr      (dcr_write_addr),
        .dcr_write_data      (dcr_write_data),
        .icache_req_valid    (icache_req_valid),
        .icache_req_ready    (icache_req_ready),
        .icache_rsp_valid    (icache_rsp_valid),
        .icache_rsp_ready    (icache_rsp_ready),
        .dcache_req_valid    (dcache_req_valid),
        .dcache_req_rw       (dcache_req_rw),
        .dcache_req_ready    (dcache_req_ready),
        .dcache_rsp_valid    (dcache_rsp_valid),
        .dcache_rsp_ready    (dcache_rsp_ready),
        .startup_addr        (startup_addr),
        .mpm_class           (mpm_class),
        .perf_ifetches       (perf_ifetches),
        .perf_loads          (perf_loads),
        .perf_stores         (perf_stores),
        .perf_ifetch_latency (perf_ifetch_latency),
        .perf_load_latency   (perf_load_latency)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Reads still outstanding, clamped to 0..max
    function automatic int outstanding(input logic signed [PERF_CTR_BITS-1:0] p, input int max);
        if (p[PERF_CTR_BITS-1] || p == '0) begin
            return 0;
        end
        if (p >= PERF_CTR_BITS'(max)) begin
            return max;
        end
        return int'(p);
    endfunction

    task automatic check_counter(input string name, input logic [PERF_CTR_BITS-1:0] got,
                                 input logic [PERF_CTR_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_class(input string name, input mpm_class_e got, input mpm_class_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [STARTUP_ADDR_BITS-1:0] got,
                              input logic [STARTUP_ADDR_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_all();
        check_addr("startup_addr", startup_addr, m_startup);
        check_class("mpm_class", mpm_class, m_class);
        check_counter("perf_ifetches", perf_ifetches, m_ifetches);
        check_counter("perf_loads", perf_loads, m_loads);
        check_counter("perf_stores", perf_stores, m_stores);
        check_counter("perf_ifetch_latency", perf_ifetch_latency, m_ilat);
        check_counter("perf_load_latency", perf_load_latency, m_dlat);
    endtask

    // Model update for one rising edge, from the strobes held before it
    task automatic model_edge();
        int i_req;
        int i_rsp;
        int rd;
        int wr;
        int rsp;
        i_req = int'(icache_req_valid & icache_req_ready);
        i_rsp = int'(icache_rsp_valid & icache_rsp_ready);
        rd = 0;
        wr = 0;
        rsp = 0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (dcache_req_valid[i] && dcache_req_ready[i]) begin
                if (dcache_req_rw[i]) wr++;
                else rd++;
            end
            if (dcache_rsp_valid[i] && dcache_rsp_ready[i]) rsp++;
        end
        if (m_class != MPM_NONE) begin
            m_ifetches = m_ifetches + PERF_CTR_BITS'(i_req);
            m_loads    = m_loads + PERF_CTR_BITS'(rd);
            m_stores   = m_stores + PERF_CTR_BITS'(wr);
            m_ilat     = m_ilat + m_ipend;
            m_dlat     = m_dlat + m_dpend;
        end
        m_ipend = m_ipend + PERF_CTR_BITS'(i_req - i_rsp);
        m_dpend = m_dpend + PERF_CTR_BITS'(rd - rsp);
        if (dcr_write_valid) begin
            if (dcr_write_addr == DCR_STARTUP_ADDR) m_startup = dcr_write_data;
            else if (dcr_write_addr == DCR_MPM_CLASS) m_class = mpm_class_e'(dcr_write_data[1:0]);
        end
    endtask

    // One clock: model follows the edge, outputs compared once settled
    task automatic step();
        @(posedge clk);
        model_edge();
        #2;
        check_all();
    endtask

    task automatic drive_idle();
        icache_req_valid = 1'b0;
        icache_req_ready = 1'b0;
        icache_rsp_valid = 1'b0;
        icache_rsp_ready = 1'b0;
        dcache_req_valid = '0;
        dcache_req_rw    = '0;
        dcache_req_ready = '0;
        dcache_rsp_valid = '0;
        dcache_rsp_ready = '0;
    endtask

    task automatic drive_traffic(input bit bounded);
        int room;
        rng = xorshift(rng);
        icache_req_valid = rng[0];
        icache_req_ready = rng[1];
        icache_rsp_valid = rng[2];
        icache_rsp_ready = rng[3];
        dcache_req_rw    = rng[4 +: NUM_LANES];
        rng = xorshift(rng);
        dcache_req_valid = rng[0 +: NUM_LANES];
        dcache_req_ready = rng[8 +: NUM_LANES];
        dcache_rsp_valid = rng[16 +: NUM_LANES];
        dcache_rsp_ready = rng[24 +: NUM_LANES];
        if (bounded) begin
            // Respond only to reads still outstanding
            if (outstanding(m_ipend, 1) == 0) icache_rsp_valid = 1'b0;
            room = outstanding(m_dpend, NUM_LANES);
            for (int i = 0; i < NUM_LANES; i++) begin
                if (dcache_rsp_valid[i] && dcache_rsp_ready[i]) begin
                    if (room == 0) dcache_rsp_valid[i] = 1'b0;
                    else room--;
                end
            end
        end
    endtask

    task automatic drive_random_dcr();
        rng = xorshift(rng);
        dcr_write_valid = rng[14] | rng[15];
        case (rng[1:0])
            2'd0:    dcr_write_addr = DCR_STARTUP_ADDR;
            2'd1:    dcr_write_addr = DCR_MPM_CLASS;
            default: dcr_write_addr = rng[13:2];
        endcase
        rng = xorshift(rng);
        dcr_write_data = rng;
    endtask

    // Upper data bits are random and must be ignored
    task automatic write_class(input mpm_class_e c, input bit busy);
        if (busy) drive_traffic(1'b1);
        else drive_idle();
        rng = xorshift(rng);
        dcr_write_valid = 1'b1;
        dcr_write_addr  = DCR_MPM_CLASS;
        dcr_write_data  = {rng[31:2], c};
        step();
        dcr_write_valid = 1'b0;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        drive_idle();
        dcr_write_valid = 1'b0;
        dcr_write_addr  = '0;
        dcr_write_data  = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        m_startup  = '0;
        m_class    = MPM_NONE;
        m_ifetches = '0;
        m_loads    = '0;
        m_stores   = '0;
        m_ilat     = '0;
        m_dlat     = '0;
        m_ipend    = '0;
        m_dpend    = '0;
    endtask

    task automatic start_test();
        errors_at_start = errors;
        checks_at_start = checks;
    endtask

    task automatic finish_test(input string name);
        int n;
        n = errors - errors_at_start;
        test_num++;
        if (n == 0) begin
            $display("Test %0d %s: passed, %0d checks", test_num, name, checks - checks_at_start);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d mismatches", test_num, name, n);
        end
    endtask

    task automatic run_traffic(input int cycles, input bit bounded);
        for (int i = 0; i < cycles; i++) begin
            drive_traffic(bounded);
            step();
        end
        drive_idle();
    endtask

    initial begin
        errors = 0;
        checks = 0;
        test_num = 0;
        tests_failed = 0;
        rng = 32'h2592_228f;
        apply_reset();

        start_test();
        check_all();
        finish_test("reset values");

        start_test();
        for (int i = 0; i < DCR_CYCLES; i++) begin
            drive_random_dcr();
            step();
        end
        dcr_write_valid = 1'b0;
        finish_test("DCR writes");

        start_test();
        write_class(MPM_NONE, 1'b0);
        run_traffic(IDLE_CYCLES, 1'b0);
        check_counter("idle perf_ifetches", perf_ifetches, '0);
        check_counter("idle perf_loads", perf_loads, '0);
        check_counter("idle perf_stores", perf_stores, '0);
        check_counter("idle perf_ifetch_latency", perf_ifetch_latency, '0);
        check_counter("idle perf_load_latency", perf_load_latency, '0);
        finish_test("counting off");

        start_test();
        write_class(MPM_CORE, 1'b0);
        run_traffic(CORE_CYCLES, 1'b0);
        finish_test("core class traffic");

        // Fresh start so responses never outrun requests
        start_test();
        apply_reset();
        check_all();
        write_class(MPM_CORE, 1'b0);
        run_traffic(BOUNDED_CYCLES, 1'b1);
        finish_test("bounded latency");

        start_test();
        run_traffic(PHASE_CYCLES, 1'b1);
        write_class(MPM_NONE, 1'b1);
        frozen_ifetches = m_ifetches;
        frozen_loads    = m_loads;
        frozen_stores   = m_stores;
        frozen_ilat     = m_ilat;
        frozen_dlat     = m_dlat;
        run_traffic(PHASE_CYCLES, 1'b1);
        check_counter("frozen perf_ifetches", perf_ifetches, frozen_ifetches);
        check_counter("frozen perf_loads", perf_loads, frozen_loads);
        check_counter("frozen perf_stores", perf_stores, frozen_stores);
        check_counter("frozen perf_ifetch_latency", perf_ifetch_latency, frozen_ilat);
        check_counter("frozen perf_load_latency", perf_load_latency, frozen_dlat);
        write_class(MPM_MEM, 1'b1);
        run_traffic(PHASE_CYCLES, 1'b1);
        checks++;
        if (perf_ifetches == frozen_ifetches) begin
            errors++;
            $display("Error at time %0t: counting did not resume after the class was set to memory",
                     $time);
        end
        finish_test("freeze and resume");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
                 test_num, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * TOTAL_CYCLES + 1000);
        $display("The run timed out before all tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* list.f */
logic/core_perf_pkg.sv
logic/mem_event_if.sv
logic/dcr_data.sv
logic/mem_traffic_decode.sv
logic/pending_latency.sv
logic/perf_counters.sv
logic/core_perf_top.sv
dv/core_perf_props.sv
dv/core_perf_tb.sv

/* logic/core_perf_pkg.sv */
package core_perf_pkg;

    // DCR write bus
    localparam int DCR_ADDR_WIDTH = 12;
    localparam int DCR_DATA_WIDTH = 32;

    // Counter and latency sum width
    localparam int PERF_CTR_BITS = 44;

    localparam int STARTUP_ADDR_BITS = 32;
    localparam int MPM_CLASS_BITS    = 2;

    // Recognized DCR addresses
    typedef enum logic [DCR_ADDR_WIDTH-1:0] {
        DCR_STARTUP_ADDR = 12'h001,
        DCR_MPM_CLASS    = 12'h003
    } dcr_addr_e;

    // Performance monitor classes
    typedef enum logic [MPM_CLASS_BITS-1:0] {
        MPM_NONE = 2'd0,
        MPM_CORE = 2'd1,
        MPM_MEM  = 2'd2
    } mpm_class_e;

    // Base configuration registers
    typedef struct packed {
        logic [STARTUP_ADDR_BITS-1:0] startup_addr;
        mpm_class_e                   mpm_class;
    } base_dcrs_t;

    // Width of a lane count, able to hold 0..lanes
    function automatic int lane_cnt_bits(input int lanes);
        return $clog2(lanes) + 1;
    endfunction

endpackage

/* logic/core_perf_top.sv */
`timescale 1ns/100ps

module core_perf_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                                       clk,
    input  logic                                       reset,

    input  logic                                       dcr_write_valid,
    input  logic [core_perf_pkg::DCR_ADDR_WIDTH-1:0]   dcr_write_addr,
    input  logic [core_perf_pkg::DCR_DATA_WIDTH-1:0]   dcr_write_data,

    input  logic                                       icache_req_valid,
    input  logic                                       icache_req_ready,
    input  logic                                       icache_rsp_valid,
    input  logic                                       icache_rsp_ready,

    input  logic [NUM_LANES-1:0]                       dcache_req_valid,
    input  logic [NUM_LANES-1:0]                       dcache_req_rw,
    input  logic [NUM_LANES-1:0]                       dcache_req_ready,
    input  logic [NUM_LANES-1:0]                       dcache_rsp_valid,
    input  logic [NUM_LANES-1:0]                       dcache_rsp_ready,

    output logic [core_perf_pkg::STARTUP_ADDR_BITS-1:0] startup_addr,
    output core_perf_pkg::mpm_class_e                  mpm_class,

    output logic [core_perf_pkg::PERF_CTR_BITS-1:0]    perf_ifetches,
    output logic [core_perf_pkg::PERF_CTR_BITS-1:0]    perf_loads,
    output logic [core_perf_pkg::PERF_CTR_BITS-1:0]    perf_stores,
    output logic [core_perf_pkg::PERF_CTR_BITS-1:0]    perf_ifetch_latency,
    output logic [core_perf_pkg::PERF_CTR_BITS-1:0]    perf_load_latency
);
    import core_perf_pkg::*;

    base_dcrs_t base_dcrs;

    mem_event_if #(
        .NUM_LANES (NUM_LANES)
    ) mem_events ();

    dcr_data dcr_data (
        .clk         (clk),
        .reset       (reset),
        .write_valid (dcr_write_valid),
        .write_addr  (dcr_write_addr),
        .write_data  (dcr_write_data),
        .base_dcrs   (base_dcrs)
    );

    assign startup_addr = base_dcrs.startup_addr;
    assign mpm_class    = base_dcrs.mpm_class;

    // Watches the strobes only, the buses are not driven here
    mem_traffic_decode #(
        .NUM_LANES (NUM_LANES)
    ) traffic_decode (
        .icache_req_valid (icache_req_valid),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp_ready (icache_rsp_ready),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req_rw    (dcache_req_rw),
        .dcache_req_ready (dcache_req_ready),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp_ready (dcache_rsp_ready),
        .events           (mem_events.decoder)
    );

    perf_counters #(
        .NUM_LANES (NUM_LANES)
    ) counters (
        .clk            (clk),
        .reset          (reset),
        .base_dcrs      (base_dcrs),
        .events         (mem_events.counter),
        .ifetches       (perf_ifetches),
        .loads          (perf_loads),
        .stores         (perf_stores),
        .ifetch_latency (perf_ifetch_latency),
        .load_latency   (perf_load_latency)
    );

endmodule

/* logic/dcr_data.sv */
`timescale 1ns/100ps

module dcr_data (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      write_valid,
    input  logic [core_perf_pkg::DCR_ADDR_WIDTH-1:0]  write_addr,
    input  logic [core_perf_pkg::DCR_DATA_WIDTH-1:0]  write_data,
    output core_perf_pkg::base_dcrs_t                 base_dcrs
);
    import core_perf_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            base_dcrs.startup_addr <= '0;
            base_dcrs.mpm_class    <= MPM_NONE;
        end else if (write_valid) begin
            case (write_addr)
                DCR_STARTUP_ADDR: begin
                    base_dcrs.startup_addr <= write_data[STARTUP_ADDR_BITS-1:0];
                end
                DCR_MPM_CLASS: begin
                    // only the low bits hold the class
                    base_dcrs.mpm_class <= mpm_class_e'(write_data[MPM_CLASS_BITS-1:0]);
                end
                default: begin
                    // Unknown address, no update
                end
            endcase
        end
    end

endmodule

/* logic/mem_event_if.sv */
`timescale 1ns/100ps

interface mem_event_if #(
    parameter int NUM_LANES = 4
);
    import core_perf_pkg::*;

    localparam int CNT_W = lane_cnt_bits(NUM_LANES);

    logic             icache_req_fire;
    logic             icache_rsp_fire;

    // Fired lanes in the current cycle
    logic [CNT_W-1:0] dcache_rd_cnt;
    logic [CNT_W-1:0] dcache_wr_cnt;
    logic [CNT_W-1:0] dcache_rsp_cnt;

    modport decoder (
        output icache_req_fire,
        output icache_rsp_fire,
        output dcache_rd_cnt,
        output dcache_wr_cnt,
        output dcache_rsp_cnt
    );

    modport counter (
        input icache_req_fire,
        input icache_rsp_fire,
        input dcache_rd_cnt,
        input dcache_wr_cnt,
        input dcache_rsp_cnt
    );

endinterface

/* logic/mem_traffic_decode.sv */
`timescale 1ns/100ps

module mem_traffic_decode #(
    parameter int NUM_LANES = 4
) (
    input  logic                 icache_req_valid,
    input  logic                 icache_req_ready,
    input  logic                 icache_rsp_valid,
    input  logic                 icache_rsp_ready,
    input  logic [NUM_LANES-1:0] dcache_req_valid,
    input  logic [NUM_LANES-1:0] dcache_req_rw,
    input  logic [NUM_LANES-1:0] dcache_req_ready,
    input  logic [NUM_LANES-1:0] dcache_rsp_valid,
    input  logic [NUM_LANES-1:0] dcache_rsp_ready,
    mem_event_if.decoder         events
);
    import core_perf_pkg::*;

    localparam int CNT_W = lane_cnt_bits(NUM_LANES);

    logic [NUM_LANES-1:0] dcache_req_fire;
    logic [NUM_LANES-1:0] dcache_rd_fire;
    logic [NUM_LANES-1:0] dcache_wr_fire;
    logic [NUM_LANES-1:0] dcache_rsp_fire;

    function automatic logic [CNT_W-1:0] pop_count(input logic [NUM_LANES-1:0] lanes);
        logic [CNT_W-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            cnt = cnt + CNT_W'(lanes[i]);
        end
        return cnt;
    endfunction

    assign events.icache_req_fire = icache_req_valid & icache_req_ready;
    assign events.icache_rsp_fire = icache_rsp_valid & icache_rsp_ready;

    // Per-lane handshakes, split by direction
    assign dcache_req_fire = dcache_req_valid & dcache_req_ready;
    assign dcache_rd_fire  = dcache_req_fire & ~dcache_req_rw;
    assign dcache_wr_fire  = dcache_req_fire & dcache_req_rw;
    assign dcache_rsp_fire = dcache_rsp_valid & dcache_rsp_ready;

    assign events.dcache_rd_cnt  = pop_count(dcache_rd_fire);
    assign events.dcache_wr_cnt  = pop_count(dcache_wr_fire);
    assign events.dcache_rsp_cnt = pop_count(dcache_rsp_fire);

endmodule

/* logic/pending_latency.sv */
`timescale 1ns/100ps

module pending_latency #(
    parameter int CNT_WIDTH = 1
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     enable,
    input  logic [CNT_WIDTH-1:0]                     issued,
    input  logic [CNT_WIDTH-1:0]                     retired,
    output logic [core_perf_pkg::PERF_CTR_BITS-1:0]  latency
);
    import core_perf_pkg::*;

    // One extra bit so the difference keeps its sign
    logic signed [CNT_WIDTH:0]         delta;
    logic signed [PERF_CTR_BITS-1:0]   delta_ext;
    logic signed [PERF_CTR_BITS-1:0]   pending;

    assign delta     = $signed({1'b0, issued}) - $signed({1'b0, retired});
    assign delta_ext = {{(PERF_CTR_BITS-CNT_WIDTH-1){delta[CNT_WIDTH]}}, delta};

    // Outstanding reads track the bus even with counting off
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= pending + delta_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            latency <= '0;
        end else if (enable) begin
            latency <= latency + pending;
        end
    end

endmodule

/* logic/perf_counters.sv */
`timescale 1ns/100ps

module perf_counters #(
    parameter int NUM_LANES = 4
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  core_perf_pkg::base_dcrs_t                base_dcrs,
    mem_event_if.counter                             events,
    output logic [core_perf_pkg::PERF_CTR_BITS-1:0]  ifetches,
    output logic [core_perf_pkg::PERF_CTR_BITS-1:0]  loads,
    output logic [core_perf_pkg::PERF_CTR_BITS-1:0]  stores,
    output logic [core_perf_pkg::PERF_CTR_BITS-1:0]  ifetch_latency,
    output logic [core_perf_pkg::PERF_CTR_BITS-1:0]  load_latency
);
    import core_perf_pkg::*;

    localparam int CNT_W = lane_cnt_bits(NUM_LANES);

    logic count_en;

    // Any class other than none turns the monitor on
    assign count_en = (base_dcrs.mpm_class != MPM_NONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            ifetches <= '0;
            loads    <= '0;
            stores   <= '0;
        end else if (count_en) begin
            ifetches <= ifetches + PERF_CTR_BITS'(events.icache_req_fire);
            loads    <= loads + PERF_CTR_BITS'(events.dcache_rd_cnt);
            stores   <= stores + PERF_CTR_BITS'(events.dcache_wr_cnt);
        end
    end

    // Instruction fetch latency
    pending_latency #(
        .CNT_WIDTH (1)
    ) icache_latency (
        .clk     (clk),
        .reset   (reset),
        .enable  (count_en),
        .issued  (events.icache_req_fire),
        .retired (events.icache_rsp_fire),
        .latency (ifetch_latency)
    );

    // Load latency, reads only
    pending_latency #(
        .CNT_WIDTH (CNT_W)
    ) dcache_latency (
        .clk     (clk),
        .reset   (reset),
        .enable  (count_en),
        .issued  (events.dcache_rd_cnt),
        .retired (events.dcache_rsp_cnt),
        .latency (load_latency)
    );

endmodule

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module core_perf_tb \
    -f list.f --Mdir obj_dir -o core_perf_sim

out=$(./obj_dir/core_perf_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^NO ERRORS$"; then
    exit 0
fi
exit 1
